//--- sim.f
decPkg.sv
decFields.sv
decClassify.sv
decOperandSelect.sv
opDecoder.sv
opDecoder_checker.sv
opDecoderTb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, then scan the log
verilator --binary --timing --assert -f sim.f --top-module opDecoderTb -o opDecoderSim \
	|| { echo "compile failed"; exit 1; }
./obj_dir/opDecoderSim > sim.log 2>&1 || { cat sim.log; echo "simulator exited with error"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
exit 0

//--- opDecoderTb.sv
`timescale 1ns/1ps

module opDecoderTb;
	import decPkg::*;

	localparam int wordsPerTest = 40;
	localparam int numTests = 6;
	// up to 8 cycles per word, plus reset and drain margin
	localparam int maxCycles = wordsPerTest * numTests * 8 + 80;
	localparam logic [31:0] seedValue = 32'h4577_ff2c;

	typedef struct packed {
		regId n;
		regId m;
		regId o;
		immValue imm;
		majorOp major;
		condCode cond;
		subOp sub;
	} expRecord;

	logic clock;
	logic reset;
	logic [instrWidth-1:0] instrWord;
	logic inValid;
	logic inReady;
	logic outReady;
	logic outValid;
	regId regN;
	regId regM;
	regId regO;
	immValue imm;
	majorOp opMajor;
	condCode opCond;
	subOp opSub;

	expRecord expQueue[$];
	integer seed = seedValue;
	integer readySeed = seedValue;
	logic [31:0] readyDraw;
	logic stallMode = 1'b0;
	int cycleCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int wordCount = 0;

	opDecoder u_opDecoder (
		.clock(clock),
		.reset(reset),
		.instrWord(instrWord),
		.inValid(inValid),
		.inReady(inReady),
		.outReady(outReady),
		.outValid(outValid),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.imm(imm),
		.opMajor(opMajor),
		.opCond(opCond),
		.opSub(opSub)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= maxCycles) begin
			$display("simulation timed out after %0d cycles", cycleCount);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// sink side, random back-pressure only when asked for
	initial begin
		outReady = 1'b1;
		forever begin
			@(posedge clock);
			#1;
			readyDraw = $random(readySeed);
			outReady = stallMode ? readyDraw[0] : 1'b1;
		end
	end

	always @(negedge clock) begin
		if (!reset && outValid && outReady) begin
			checkOutput();
		end
	end

	task automatic checkReg(input string name, input regId expected, input regId actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkImm(input string name, input immValue expected, input immValue actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkMajor(input string name, input majorOp expected, input majorOp actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0t %s expected %s actual %s (%h)", $time, name,
				expected.name(), actual.name(), actual);
		end
	endtask

	task automatic checkCond(input string name, input condCode expected, input condCode actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0t %s expected %s actual %s (%h)", $time, name,
				expected.name(), actual.name(), actual);
		end
	endtask

	task automatic checkSub(input string name, input subOp expected, input subOp actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("[FAIL] %0t %s expected %s actual %s (%h)", $time, name,
				expected.name(), actual.name(), actual);
		end
	endtask

	task automatic checkOutput();
		expRecord e;
		if (expQueue.size() == 0) begin
			errorCount++;
			$display("output at %0t came out with no word waiting for it", $time);
		end else begin
			e = expQueue.pop_front();
			checkReg("regN", e.n, regN);
			checkReg("regM", e.m, regM);
			checkReg("regO", e.o, regO);
			checkImm("imm", e.imm, imm);
			checkMajor("opMajor", e.major, opMajor);
			checkCond("opCond", e.cond, opCond);
			checkSub("opSub", e.sub, opSub);
		end
	endtask

	// 4-bit field plus extension bit, low fields and RF land in the upper half
	function automatic regId fieldToReg(input logic [3:0] field, input logic ext);
		regId sel;
		sel = {2'b00, field};
		sel[4] = ext;
		if (!ext && (field <= 4'd1 || field == 4'hF)) begin
			sel[5] = 1'b1;
		end
		return sel;
	endfunction

	function automatic expRecord invalidRecord();
		expRecord e;
		e.n = regZzr;
		e.m = regZzr;
		e.o = regZzr;
		e.imm = '0;
		e.major = INVOP;
		e.cond = AL;
		e.sub = ADD;
		return e;
	endfunction

	// called 1 ns after a rising edge, returns 1 ns after the accepting edge
	task automatic sendWord(input logic [31:0] word, input expRecord expected);
		logic accepted;
		instrWord = word;
		inValid = 1'b1;
		expQueue.push_back(expected);
		wordCount++;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clock);
			accepted = inReady;
			@(posedge clock);
			#1;
		end
		inValid = 1'b0;
	endtask

	task automatic drainOutputs();
		while (expQueue.size() != 0) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic sendRegAlu(input int i);
		logic [31:0] r;
		logic [31:0] w;
		logic [3:0] minor;
		expRecord e;
		r = $random(seed);
		case (i % 6)
			0: minor = 4'h0;
			1: minor = 4'h1;
			2: minor = 4'h2;
			3: minor = 4'h5;
			4: minor = 4'h6;
			default: minor = 4'h7;
		endcase
		w = {4'h1, r[27:20], minor, 8'hF0, r[7:0]};
		e = invalidRecord();
		e.n = fieldToReg(w[7:4], w[26]);
		e.m = fieldToReg(w[3:0], w[25]);
		e.o = fieldToReg(w[23:20], w[24]);
		e.imm = {28'd0, w[4:0]};
		e.major = ALU3;
		case (minor)
			4'h0: e.sub = ADD;
			4'h1: e.sub = SUB;
			4'h2: e.major = MUL3;
			4'h5: e.sub = AND;
			4'h6: e.sub = OR;
			default: e.sub = XOR;
		endcase
		sendWord(w, e);
	endtask

	task automatic sendMemIndexed(input int i);
		logic [31:0] r;
		logic [31:0] w;
		logic [3:0] minor;
		expRecord e;
		r = $random(seed);
		minor = {i[2], 1'b1, i[1:0]};
		w = {4'h0, r[27:20], minor, 8'hF0, r[7:0]};
		// steer some words onto R0 and R1 bases
		if (r[9:8] == 2'd0) begin
			w[3:0] = 4'h0;
			w[25] = 1'b0;
		end else if (r[9:8] == 2'd1) begin
			w[3:0] = 4'h1;
			w[25] = 1'b0;
		end
		e = invalidRecord();
		e.n = fieldToReg(w[7:4], w[26]);
		e.o = fieldToReg(w[23:20], w[24]);
		e.imm = '0;
		if (w[3:0] == 4'h1 && !w[25]) begin
			e.m = regGbr;
		end else if (w[3:0] == 4'h0 && !w[25]) begin
			e.m = regPc;
		end else begin
			e.m = fieldToReg(w[3:0], w[25]);
		end
		if (!minor[3]) begin
			e.major = w[27] ? LEAMR : MOVRM;
			case (minor[1:0])
				2'd0: e.sub = SB;
				2'd1: e.sub = SW;
				2'd2: e.sub = SL;
				default: e.sub = SQ;
			endcase
		end else begin
			e.major = MOVMR;
			case (minor[1:0])
				2'd0: e.sub = w[27] ? UB : SB;
				2'd1: e.sub = w[27] ? UW : SW;
				2'd2: e.sub = w[27] ? UL : SL;
				default: e.sub = w[27] ? SL : SQ;
			endcase
		end
		sendWord(w, e);
	endtask

	task automatic sendImmAlu(input int i);
		logic [31:0] r;
		logic [31:0] w;
		logic [3:0] minor;
		expRecord e;
		r = $random(seed);
		case (i % 5)
			0: minor = 4'h0;
			1: minor = 4'h1;
			2: minor = 4'h5;
			3: minor = 4'h6;
			default: minor = 4'h7;
		endcase
		w = {minor, r[27:16], 8'hF2, r[7:0]};
		e = invalidRecord();
		e.n = fieldToReg(w[7:4], w[26]);
		e.m = fieldToReg(w[3:0], w[25]);
		e.o = regImm;
		e.imm = (minor == 4'h1) ? {24'hFF_FFFF, w[24:16]} : {24'h0, w[24:16]};
		e.major = ALU3;
		case (minor)
			4'h5: e.sub = AND;
			4'h6: e.sub = OR;
			4'h7: e.sub = XOR;
			default: e.sub = ADD;
		endcase
		sendWord(w, e);
	endtask

	task automatic sendBranch(input int i);
		logic [31:0] r;
		logic [31:0] w;
		logic [3:0] top;
		logic [19:0] disp;
		expRecord e;
		r = $random(seed);
		top = {2'b11, i[1:0]};
		w = {top, r[27:16], 8'hF0, r[7:0]};
		disp = {w[7:0], w[27:16]};
		e = invalidRecord();
		e.n = regDlr;
		e.m = regPc;
		e.o = regImm;
		e.imm = {{13{disp[19]}}, disp};
		e.major = (top == 4'hD) ? BSR : BRA;
		if (top == 4'hE) begin
			e.cond = CT;
		end else if (top == 4'hF) begin
			e.cond = CF;
		end
		sendWord(w, e);
	endtask

	task automatic sendLoadImm(input int i);
		logic [31:0] r;
		logic [31:0] w;
		logic ones;
		regId dst;
		expRecord e;
		r = $random(seed);
		ones = i[0];
		e = invalidRecord();
		e.major = MOVIR;
		e.sub = LDIX;
		if (!i[1]) begin
			w = {r[31:16], 8'hF8, 2'b00, ones, r[4:0]};
			dst = fieldToReg(w[3:0], w[4]);
			e.n = dst;
			e.m = regImm;
			e.o = dst;
			e.imm = {{17{ones}}, w[31:16]};
		end else begin
			// FA or FB, picked by the ones bit
			w = {r[31:16], 7'b1111_101, ones, r[7:0]};
			e.n = regDlr;
			e.m = regDlr;
			e.o = regImm;
			e.imm = {{9{ones}}, w[7:0], w[31:16]};
		end
		sendWord(w, e);
	endtask

	task automatic sendInvalid(input int i);
		logic [31:0] r;
		logic [31:0] w;
		logic [3:0] top;
		logic [3:0] minor;
		logic [3:0] blk;
		r = $random(seed);
		case (i % 7)
			0: begin
				w = r;
				if (w[15:13] == 3'b111) begin
					w[14] = 1'b0;
				end
			end
			1: w = {4'h0, r[27:20], r[19], 1'b0, r[17:16], 8'hF0, r[7:0]};
			2: begin
				if (r[19]) begin
					minor = {1'b1, r[18:16]};
				end else if (r[18]) begin
					minor = 4'h3;
				end else begin
					minor = 4'h4;
				end
				w = {4'h1, r[27:20], minor, 8'hF0, r[7:0]};
			end
			3: begin
				if (r[31:30] == 2'b00) begin
					top = {3'b001, r[28]};
				end else begin
					top = {r[31], !r[31], r[29:28]};
				end
				w = {top, r[27:16], 8'hF0, r[7:0]};
			end
			4: begin
				if (r[31]) begin
					top = r[31:28];
				end else if (r[30]) begin
					top = 4'h4;
				end else begin
					top = {3'b001, r[28]};
				end
				w = {top, r[27:16], 8'hF2, r[7:0]};
			end
			5: begin
				w = {r[31:16], 8'hF8, r[7:0]};
				if (w[7:6] == 2'b00) begin
					w[7] = 1'b1;
				end
			end
			default: begin
				// unused blocks 1,3,5,7 and C-F
				blk = r[11] ? {2'b11, r[9:8]} : {1'b0, r[10:9], 1'b1};
				w = {r[31:16], 4'hF, blk, r[7:0]};
			end
		endcase
		sendWord(w, invalidRecord());
	endtask

	task automatic reportTest(input string name, input int startErrors);
		$display("test %s finished, %0d errors", name, errorCount - startErrors);
	endtask

	task automatic testRegAlu();
		int i;
		int startErrors;
		startErrors = errorCount;
		for (i = 0; i < wordsPerTest; i++) begin
			sendRegAlu(i);
		end
		drainOutputs();
		reportTest("reg-reg alu", startErrors);
	endtask

	task automatic testMemIndexed();
		int i;
		int startErrors;
		startErrors = errorCount;
		for (i = 0; i < wordsPerTest; i++) begin
			sendMemIndexed(i);
		end
		drainOutputs();
		reportTest("indexed memory", startErrors);
	endtask

	task automatic testImmAlu();
		int i;
		int startErrors;
		startErrors = errorCount;
		for (i = 0; i < wordsPerTest; i++) begin
			sendImmAlu(i);
		end
		drainOutputs();
		reportTest("immediate alu", startErrors);
	endtask

	task automatic testBranch();
		int i;
		int startErrors;
		startErrors = errorCount;
		for (i = 0; i < wordsPerTest; i++) begin
			sendBranch(i);
		end
		drainOutputs();
		reportTest("branch", startErrors);
	endtask

	task automatic testLoadImm();
		int i;
		int startErrors;
		startErrors = errorCount;
		for (i = 0; i < wordsPerTest; i++) begin
			sendLoadImm(i);
		end
		drainOutputs();
		reportTest("load immediate", startErrors);
	endtask

	// invalid words mixed with valid ones under random back-pressure
	task automatic testInvalidStall();
		int i;
		int startErrors;
		startErrors = errorCount;
		stallMode = 1'b1;
		for (i = 0; i < wordsPerTest; i++) begin
			if (i % 2 == 0) begin
				sendInvalid(i / 2);
			end else begin
				case ((i / 2) % 5)
					0: sendRegAlu(i);
					1: sendMemIndexed(i);
					2: sendImmAlu(i);
					3: sendBranch(i);
					default: sendLoadImm(i);
				endcase
			end
		end
		drainOutputs();
		stallMode = 1'b0;
		reportTest("invalid and back-pressure", startErrors);
	endtask

	initial begin
		reset = 1'b1;
		instrWord = '0;
		inValid = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		testRegAlu();
		testMemIndexed();
		testImmAlu();
		testBranch();
		testLoadImm();
		testInvalidStall();

		$display("words %0d, checks %0d, errors %0d", wordCount, checkCount, errorCount);
		if (errorCount == 0 && expQueue.size() == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- opDecoder_checker.sv
`timescale 1ns/1ps

module opDecoder_checker (
	input logic clock,
	input logic reset,
	input logic inValid,
	input logic inReady,
	input logic outReady,
	input logic outValid,
	input decPkg::regId regN,
	input decPkg::regId regM,
	input decPkg::regId regO,
	input decPkg::immValue imm,
	input decPkg::majorOp opMajor,
	input decPkg::condCode opCond,
	input decPkg::subOp opSub
);

	resetClearsValid: assert property (@(posedge clock) reset |=> !outValid)
		else $error("outValid high right after reset");

	// stalled output must not move
	holdWhileStalled: assert property (@(posedge clock) disable iff (reset)
		(outValid && !outReady) |=> (outValid && $stable(regN) && $stable(regM)
			&& $stable(regO) && $stable(imm) && $stable(opMajor)
			&& $stable(opCond) && $stable(opSub)))
		else $error("outputs changed while stalled");

	acceptToOutput: assert property (@(posedge clock) disable iff (reset)
		($past(inValid && inReady && outReady) && outReady) |=> outValid)
		else $error("accepted word did not reach the output in 2 cycles");

endmodule

bind opDecoder opDecoder_checker u_opDecoderChecker (
	.clock(clock),
	.reset(reset),
	.inValid(inValid),
	.inReady(inReady),
	.outReady(outReady),
	.outValid(outValid),
	.regN(regN),
	.regM(regM),
	.regO(regO),
	.imm(imm),
	.opMajor(opMajor),
	.opCond(opCond),
	.opSub(opSub)
);

//--- opDecoder.sv
`timescale 1ns/1ps

module opDecoder (
	input logic clock,
	input logic reset,
	input logic [decPkg::instrWidth-1:0] instrWord,
	input logic inValid,
	output logic inReady,
	input logic outReady,
	output logic outValid,
	output decPkg::regId regN,
	output decPkg::regId regM,
	output decPkg::regId regO,
	output decPkg::immValue imm,
	output decPkg::majorOp opMajor,
	output decPkg::condCode opCond,
	output decPkg::subOp opSub
);
	import decPkg::*;

	regId rnDfl;
	regId rmDfl;
	regId roDfl;
	logic rmIsR0;
	logic rmIsR1;
	logic [23:0] immBits;

	logic s1Valid;
	majorOp s1Major;
	condCode s1Cond;
	subOp s1Sub;
	opForm s1Form;
	immKind s1Kind;

	// inReady doubles as the pipeline advance
	decFields u_decFields (
		.clock(clock),
		.reset(reset),
		.advance(inReady),
		.instrWord(instrWord),
		.rnDfl(rnDfl),
		.rmDfl(rmDfl),
		.roDfl(roDfl),
		.rmIsR0(rmIsR0),
		.rmIsR1(rmIsR1),
		.immBits(immBits)
	);

	decClassify u_decClassify (
		.clock(clock),
		.reset(reset),
		.advance(inReady),
		.inValid(inValid),
		.instrWord(instrWord),
		.s1Valid(s1Valid),
		.opMajor(s1Major),
		.opCond(s1Cond),
		.opSub(s1Sub),
		.opForm(s1Form),
		.immSign(s1Kind)
	);

	decOperandSelect u_decOperandSelect (
		.clock(clock),
		.reset(reset),
		.outReady(outReady),
		.s1Valid(s1Valid),
		.opMajor(s1Major),
		.opCond(s1Cond),
		.opSub(s1Sub),
		.opForm(s1Form),
		.immSign(s1Kind),
		.rnDfl(rnDfl),
		.rmDfl(rmDfl),
		.roDfl(roDfl),
		.rmIsR0(rmIsR0),
		.rmIsR1(rmIsR1),
		.immBits(immBits),
		.advance(inReady),
		.outValid(outValid),
		.regN(regN),
		.regM(regM),
		.regO(regO),
		.imm(imm),
		.outMajor(opMajor),
		.outCond(opCond),
		.outSub(opSub)
	);

endmodule

//--- decOperandSelect.sv
`timescale 1ns/1ps

module decOperandSelect (
	input logic clock,
	input logic reset,
	input logic outReady,
	input logic s1Valid,
	input decPkg::majorOp opMajor,
	input decPkg::condCode opCond,
	input decPkg::subOp opSub,
	input decPkg::opForm opForm,
	input decPkg::immKind immSign,
	input decPkg::regId rnDfl,
	input decPkg::regId rmDfl,
	input decPkg::regId roDfl,
	input logic rmIsR0,
	input logic rmIsR1,
	input logic [23:0] immBits,
	output logic advance,
	output logic outValid,
	output decPkg::regId regN,
	output decPkg::regId regM,
	output decPkg::regId regO,
	output decPkg::immValue imm,
	output decPkg::majorOp outMajor,
	output decPkg::condCode outCond,
	output decPkg::subOp outSub
);
	import decPkg::*;

	regId nNext;
	regId mNext;
	regId oNext;
	regId dstF8;
	immValue immNext;
	logic fill;

	// empty or draining this cycle
	assign advance = !outValid || outReady;

	assign fill = (immSign == ONES);

	// F8 target register comes from the low five bits of the word
	assign dstF8 = buildSel(immBits[19:16], immBits[20]);

	always_comb begin
		nNext = regZzr;
		mNext = regZzr;
		oNext = regZzr;
		immNext = '0;

		case (opForm)
			REGREG: begin
				nNext = rnDfl;
				mNext = rmDfl;
				oNext = roDfl;
				immNext = {28'd0, immBits[20:16]};
			end
			REGIMMREG: begin
				nNext = rnDfl;
				mNext = rmDfl;
				oNext = regImm;
				immNext = {{24{fill}}, immBits[8:0]};
			end
			LDDR: begin
				nNext = rnDfl;
				oNext = roDfl;
				if (rmIsR1) begin
					mNext = regGbr;
				end else if (rmIsR0) begin
					mNext = regPc;
				end else begin
					mNext = rmDfl;
				end
			end
			PCDISP: begin
				nNext = regDlr;
				mNext = regPc;
				oNext = regImm;
				// sign taken from bit 7 of the word
				immNext = {{13{immBits[23]}}, immBits[23:16], immBits[11:0]};
			end
			IMM16REG: begin
				nNext = dstF8;
				mNext = regImm;
				oNext = dstF8;
				immNext = {{17{fill}}, immBits[15:0]};
			end
			IMM24: begin
				nNext = regDlr;
				mNext = regDlr;
				oNext = regImm;
				immNext = {{9{fill}}, immBits};
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			outValid <= 1'b0;
		end else if (advance) begin
			outValid <= s1Valid;
		end
	end

	// held while stalled
	always_ff @(posedge clock) begin
		if (advance) begin
			regN <= nNext;
			regM <= mNext;
			regO <= oNext;
			imm <= immNext;
			outMajor <= opMajor;
			outCond <= opCond;
			outSub <= opSub;
		end
	end

endmodule

//--- decClassify.sv
`timescale 1ns/1ps

module decClassify (
	input logic clock,
	input logic reset,
	input logic advance,
	input logic inValid,
	input logic [decPkg::instrWidth-1:0] instrWord,
	output logic s1Valid,
	output decPkg::majorOp opMajor,
	output decPkg::condCode opCond,
	output decPkg::subOp opSub,
	output decPkg::opForm opForm,
	output decPkg::immKind immSign
);
	import decPkg::*;

	majorOp majorNext;
	condCode condNext;
	subOp subNext;
	decPkg::opForm formNext;
	immKind kindNext;
	logic qBit;

	assign qBit = instrWord[27];

	always_comb begin
		majorNext = INVOP;
		condNext = AL;
		subNext = ADD;
		formNext = Z;
		kindNext = ZERO;

		case (instrWord[11:8])
			4'h0: begin
				casez (instrWord[31:16])
					16'h0zz4, 16'h0zz5, 16'h0zz6, 16'h0zz7: begin
						majorNext = qBit ? LEAMR : MOVRM;
						formNext = LDDR;
						case (instrWord[17:16])
							2'd0: subNext = SB;
							2'd1: subNext = SW;
							2'd2: subNext = SL;
							default: subNext = SQ;
						endcase
					end
					16'h0zzC, 16'h0zzD, 16'h0zzE, 16'h0zzF: begin
						majorNext = MOVMR;
						formNext = LDDR;
						// Q picks the unsigned width, except on F
						case (instrWord[17:16])
							2'd0: subNext = qBit ? UB : SB;
							2'd1: subNext = qBit ? UW : SW;
							2'd2: subNext = qBit ? UL : SL;
							default: subNext = qBit ? SL : SQ;
						endcase
					end
					16'h1zz0: begin
						majorNext = ALU3;
						formNext = REGREG;
						subNext = ADD;
					end
					16'h1zz1: begin
						majorNext = ALU3;
						formNext = REGREG;
						subNext = SUB;
					end
					16'h1zz2: begin
						majorNext = MUL3;
						formNext = REGREG;
						subNext = ADD;
					end
					16'h1zz5: begin
						majorNext = ALU3;
						formNext = REGREG;
						subNext = AND;
					end
					16'h1zz6: begin
						majorNext = ALU3;
						formNext = REGREG;
						subNext = OR;
					end
					16'h1zz7: begin
						majorNext = ALU3;
						formNext = REGREG;
						subNext = XOR;
					end
					// 20-bit pc-relative branches
					16'hCzzz: begin
						majorNext = BRA;
						formNext = PCDISP;
					end
					16'hDzzz: begin
						majorNext = BSR;
						formNext = PCDISP;
					end
					16'hEzzz: begin
						majorNext = BRA;
						formNext = PCDISP;
						condNext = CT;
					end
					16'hFzzz: begin
						majorNext = BRA;
						formNext = PCDISP;
						condNext = CF;
					end
					default: begin
					end
				endcase
			end
			4'h2: begin
				case (instrWord[31:28])
					4'h0, 4'h1: begin
						majorNext = ALU3;
						formNext = REGIMMREG;
						subNext = ADD;
						kindNext = instrWord[28] ? ONES : ZERO;
					end
					4'h5: begin
						majorNext = ALU3;
						formNext = REGIMMREG;
						subNext = AND;
					end
					4'h6: begin
						majorNext = ALU3;
						formNext = REGIMMREG;
						subNext = OR;
					end
					4'h7: begin
						majorNext = ALU3;
						formNext = REGIMMREG;
						subNext = XOR;
					end
					default: begin
					end
				endcase
			end
			4'h8: begin
				if (instrWord[7:6] == 2'b00) begin
					majorNext = MOVIR;
					formNext = IMM16REG;
					subNext = LDIX;
					kindNext = instrWord[5] ? ONES : ZERO;
				end
			end
			4'hA, 4'hB: begin
				majorNext = MOVIR;
				formNext = IMM24;
				subNext = LDIX;
				kindNext = instrWord[8] ? ONES : ZERO;
			end
			default: begin
			end
		endcase

		// outside the F block nothing decodes
		if (instrWord[15:13] != 3'b111) begin
			majorNext = INVOP;
			condNext = AL;
			subNext = ADD;
			formNext = Z;
			kindNext = ZERO;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			s1Valid <= 1'b0;
		end else if (advance) begin
			s1Valid <= inValid;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			opMajor <= majorNext;
			opCond <= condNext;
			opSub <= subNext;
			opForm <= formNext;
			immSign <= kindNext;
		end
	end

endmodule

//--- decFields.sv
`timescale 1ns/1ps

module decFields (
	input logic clock,
	input logic reset,
	input logic advance,
	input logic [decPkg::instrWidth-1:0] instrWord,
	output decPkg::regId rnDfl,
	output decPkg::regId rmDfl,
	output decPkg::regId roDfl,
	output logic rmIsR0,
	output logic rmIsR1,
	output logic [23:0] immBits
);
	import decPkg::*;

	regId rnNext;
	regId rmNext;
	regId roNext;

	// Rn from 7:4, Rm from 3:0, Ro from 23:20
	assign rnNext = buildSel(instrWord[7:4], instrWord[26]);
	assign rmNext = buildSel(instrWord[3:0], instrWord[25]);
	assign roNext = buildSel(instrWord[23:20], instrWord[24]);

	always_ff @(posedge clock) begin
		if (reset) begin
			rnDfl <= regZzr;
			rmDfl <= regZzr;
			roDfl <= regZzr;
			rmIsR0 <= 1'b0;
			rmIsR1 <= 1'b0;
		end else if (advance) begin
			rnDfl <= rnNext;
			rmDfl <= rmNext;
			roDfl <= roNext;
			// base register flags for the PC/GBR substitution
			rmIsR0 <= (rmNext[4:0] == 5'd0);
			rmIsR1 <= (rmNext[4:0] == 5'd1);
		end
	end

	// low byte on top, upper halfword below
	always_ff @(posedge clock) begin
		if (advance) begin
			immBits <= {instrWord[7:0], instrWord[31:16]};
		end
	end

endmodule

//--- decPkg.sv
package decPkg;

	localparam int instrWidth = 32;
	localparam int regIdWidth = 6;
	localparam int immWidth = 33;

	typedef logic [regIdWidth-1:0] regId;
	typedef logic [immWidth-1:0] immValue;

	// special register numbers
	localparam regId regZzr = 6'h3F;
	localparam regId regImm = 6'h3E;
	localparam regId regDlr = 6'h30;
	localparam regId regPc = 6'h20;
	localparam regId regGbr = 6'h21;

	typedef enum logic [3:0] {
		INVOP = 4'h0,
		NOP = 4'h1,
		MOVRM = 4'h2,
		MOVMR = 4'h3,
		LEAMR = 4'h4,
		ALU3 = 4'h5,
		MUL3 = 4'h6,
		BRA = 4'h7,
		BSR = 4'h8,
		MOVIR = 4'h9
	} majorOp;

	// branch and predication condition
	typedef enum logic [1:0] {
		AL = 2'd0,
		CT = 2'd1,
		CF = 2'd2
	} condCode;

	// alu codes share the space with the memory access sizes
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		AND = 4'h2,
		OR = 4'h3,
		XOR = 4'h4,
		LDIX = 4'h5,
		SB = 4'h8,
		SW = 4'h9,
		SL = 4'hA,
		SQ = 4'hB,
		UB = 4'hC,
		UW = 4'hD,
		UL = 4'hE
	} subOp;

	// operand layout handed from stage one to stage two
	typedef enum logic [2:0] {
		Z = 3'd0,
		REGREG = 3'd1,
		REGIMMREG = 3'd2,
		LDDR = 3'd3,
		PCDISP = 3'd4,
		IMM16REG = 3'd5,
		IMM24 = 3'd6
	} opForm;

	typedef enum logic {
		ZERO = 1'b0,
		ONES = 1'b1
	} immKind;

	// 4-bit field plus extension bit gives the 6-bit selector;
	// low fields and RF map into the upper half unless extended
	function automatic regId buildSel(input logic [3:0] field, input logic ext);
		logic hiBit;
		hiBit = ((field[3:1] == 3'b000) || (field == 4'hF)) && !ext;
		return {hiBit, ext, field};
	endfunction

endpackage
